//--- design/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // bus geometry
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;
    localparam int resp_w = 2;

    // sram size, 256 words = 1 KiB window
    localparam int mem_words  = 256;
    localparam int word_idx_w = $clog2(mem_words);

    localparam logic [resp_w-1:0] resp_okay   = 2'b00;
    localparam logic [resp_w-1:0] resp_decerr = 2'b11;

    // master to slave, all five channels
    typedef struct packed {
        logic [addr_w-1:0] araddr;
        logic              arvalid;
        logic [addr_w-1:0] awaddr;
        logic              awvalid;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] wstrb;
        logic              wvalid;
        logic              rready;
        logic              bready;
    } axi_m2s_t;

    // slave to master
    typedef struct packed {
        logic              arready;
        logic [data_w-1:0] rdata;
        logic [resp_w-1:0] rresp;
        logic              rvalid;
        logic              awready;
        logic              wready;
        logic [resp_w-1:0] bresp;
        logic              bvalid;
    } axi_s2m_t;

    typedef enum logic [1:0] {sram_idle, sram_read, sram_write} sram_state_e;

    typedef enum logic [1:0] {port_idle, port_addr, port_resp} port_state_e;

    typedef enum logic [1:0] {grant_none, grant_ifetch, grant_lsu} grant_e;

endpackage

`default_nettype wire

//--- design/axi_lite_sram.sv
`default_nettype none

module axi_lite_sram (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::axi_m2s_t bus_in,
    output mem_pkg::axi_s2m_t bus_out
);

    mem_pkg::sram_state_e state;
    mem_pkg::sram_state_e next_state;

    logic [2:0] lfsr;
    logic [2:0] wait_cnt;
    logic       sram_ack;

    // request captured at the address handshake
    logic [mem_pkg::addr_w-1:0] addr_q;
    logic [mem_pkg::data_w-1:0] wdata_q;
    logic [mem_pkg::strb_w-1:0] wstrb_q;

    logic [mem_pkg::data_w-1:0] rdata_q;
    logic [mem_pkg::resp_w-1:0] resp_q;

    logic [mem_pkg::data_w-1:0] mem [mem_pkg::mem_words];

    logic                           idle;
    logic                           ar_hs;
    logic                           w_hs;
    logic                           access;
    logic                           in_range;
    logic [mem_pkg::word_idx_w-1:0] word_idx;

    assign idle  = (state == mem_pkg::sram_idle);
    assign ar_hs = idle && bus_in.arvalid;
    // reads win if both arrive together
    assign w_hs  = idle && !bus_in.arvalid && bus_in.awvalid && bus_in.wvalid;

    // access happens once, when the wait counter reaches the lfsr value
    assign access   = !idle && !sram_ack && (wait_cnt == lfsr);
    assign in_range = (addr_q[mem_pkg::addr_w-1:mem_pkg::word_idx_w+2] == '0);
    assign word_idx = addr_q[mem_pkg::word_idx_w+1:2];

    always_comb begin
        next_state = state;
        case (state)
            mem_pkg::sram_idle: begin
                if (ar_hs) begin
                    next_state = mem_pkg::sram_read;
                end else if (w_hs) begin
                    next_state = mem_pkg::sram_write;
                end
            end
            mem_pkg::sram_read: begin
                if (sram_ack && bus_in.rready) begin
                    next_state = mem_pkg::sram_idle;
                end
            end
            mem_pkg::sram_write: begin
                if (sram_ack && bus_in.bready) begin
                    next_state = mem_pkg::sram_idle;
                end
            end
            default: begin
                next_state = mem_pkg::sram_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= mem_pkg::sram_idle;
            lfsr     <= 3'b001;
            wait_cnt <= '0;
            sram_ack <= 1'b0;
        end else begin
            state <= next_state;
            if (idle) begin
                // x^3 + x^2 + 1, never reaches zero
                lfsr     <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
                wait_cnt <= '0;
                sram_ack <= 1'b0;
            end else if (access) begin
                sram_ack <= 1'b1;
            end else if (!sram_ack) begin
                wait_cnt <= wait_cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            addr_q <= bus_in.araddr;
        end else if (w_hs) begin
            addr_q  <= bus_in.awaddr;
            wdata_q <= bus_in.wdata;
            wstrb_q <= bus_in.wstrb;
        end

        if (access) begin
            if (in_range) begin
                resp_q <= mem_pkg::resp_okay;
                if (state == mem_pkg::sram_read) begin
                    rdata_q <= mem[word_idx];
                end else begin
                    // byte-wise merge under the strobes
                    for (int b = 0; b < mem_pkg::strb_w; b++) begin
                        if (wstrb_q[b]) begin
                            mem[word_idx][8*b +: 8] <= wdata_q[8*b +: 8];
                        end
                    end
                end
            end else begin
                resp_q  <= mem_pkg::resp_decerr;
                rdata_q <= '0;
            end
        end
    end

    assign bus_out.arready = idle;
    assign bus_out.awready = idle && !bus_in.arvalid && bus_in.wvalid;
    assign bus_out.wready  = w_hs;
    assign bus_out.rdata   = rdata_q;
    assign bus_out.rresp   = resp_q;
    assign bus_out.rvalid  = (state == mem_pkg::sram_read) && sram_ack;
    assign bus_out.bresp   = resp_q;
    assign bus_out.bvalid  = (state == mem_pkg::sram_write) && sram_ack;

endmodule

`default_nettype wire

//--- design/axi_lite_arbiter.sv
`default_nettype none

module axi_lite_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::axi_m2s_t ifetch_bus_in,
    input  mem_pkg::axi_m2s_t lsu_bus_in,
    output mem_pkg::axi_s2m_t ifetch_bus_out,
    output mem_pkg::axi_s2m_t lsu_bus_out,
    output mem_pkg::axi_m2s_t sram_bus_out,
    input  mem_pkg::axi_s2m_t sram_bus_in
);

    mem_pkg::grant_e owner;
    mem_pkg::grant_e next_owner;

    // set when lsu was the last one granted
    logic last_lsu;

    logic ifetch_req;
    logic lsu_req;
    logic resp_hs;

    assign ifetch_req = ifetch_bus_in.arvalid || ifetch_bus_in.awvalid;
    assign lsu_req    = lsu_bus_in.arvalid || lsu_bus_in.awvalid;

    // transaction ends on the R or B handshake seen at the slave
    assign resp_hs = (sram_bus_in.rvalid && sram_bus_out.rready)
                  || (sram_bus_in.bvalid && sram_bus_out.bready);

    always_comb begin
        next_owner = owner;
        case (owner)
            mem_pkg::grant_none: begin
                if (ifetch_req && lsu_req) begin
                    next_owner = last_lsu ? mem_pkg::grant_ifetch : mem_pkg::grant_lsu;
                end else if (ifetch_req) begin
                    next_owner = mem_pkg::grant_ifetch;
                end else if (lsu_req) begin
                    next_owner = mem_pkg::grant_lsu;
                end
            end
            default: begin
                if (resp_hs) begin
                    next_owner = mem_pkg::grant_none;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner    <= mem_pkg::grant_none;
            last_lsu <= 1'b0;
        end else begin
            owner <= next_owner;
            if (owner == mem_pkg::grant_none && next_owner != mem_pkg::grant_none) begin
                last_lsu <= (next_owner == mem_pkg::grant_lsu);
            end
        end
    end

    // route the owner, everyone else sees an idle bus
    always_comb begin
        sram_bus_out   = '0;
        ifetch_bus_out = '0;
        lsu_bus_out    = '0;
        case (owner)
            mem_pkg::grant_ifetch: begin
                sram_bus_out   = ifetch_bus_in;
                ifetch_bus_out = sram_bus_in;
            end
            mem_pkg::grant_lsu: begin
                sram_bus_out = lsu_bus_in;
                lsu_bus_out  = sram_bus_in;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/ifetch_port.sv
`default_nettype none

module ifetch_port (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              fetch_req,
    input  logic [31:0]       fetch_addr,
    output logic              fetch_busy,
    output logic              fetch_done,
    output logic              fetch_err,
    output logic [31:0]       fetch_data,
    output mem_pkg::axi_m2s_t bus_out,
    input  mem_pkg::axi_s2m_t bus_in
);

    mem_pkg::port_state_e state;

    logic [31:0] addr_q;
    logic        accept;
    logic        ar_hs;
    logic        r_hs;

    assign accept = (state == mem_pkg::port_idle) && fetch_req;
    assign ar_hs  = (state == mem_pkg::port_addr) && bus_in.arready;
    // rready is tied high, so rvalid alone completes R
    assign r_hs   = (state == mem_pkg::port_resp) && bus_in.rvalid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= mem_pkg::port_idle;
            fetch_done <= 1'b0;
        end else begin
            fetch_done <= r_hs;
            case (state)
                mem_pkg::port_idle: if (accept) state <= mem_pkg::port_addr;
                mem_pkg::port_addr: if (ar_hs) state <= mem_pkg::port_resp;
                mem_pkg::port_resp: if (r_hs) state <= mem_pkg::port_idle;
                default:            state <= mem_pkg::port_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= fetch_addr;
        end
        if (r_hs) begin
            fetch_data <= bus_in.rdata;
            fetch_err  <= (bus_in.rresp != mem_pkg::resp_okay);
        end
    end

    assign fetch_busy = (state != mem_pkg::port_idle);

    // read-only master
    assign bus_out.araddr  = addr_q;
    assign bus_out.arvalid = (state == mem_pkg::port_addr);
    assign bus_out.awaddr  = '0;
    assign bus_out.awvalid = 1'b0;
    assign bus_out.wdata   = '0;
    assign bus_out.wstrb   = '0;
    assign bus_out.wvalid  = 1'b0;
    assign bus_out.rready  = 1'b1;
    assign bus_out.bready  = 1'b1;

endmodule

`default_nettype wire

//--- design/lsu_port.sv
`default_nettype none

module lsu_port (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              lsu_req,
    input  logic              lsu_we,
    input  logic [31:0]       lsu_addr,
    input  logic [31:0]       lsu_wdata,
    input  logic [3:0]        lsu_wstrb,
    output logic              lsu_busy,
    output logic              lsu_done,
    output logic              lsu_err,
    output logic [31:0]       lsu_rdata,
    output mem_pkg::axi_m2s_t bus_out,
    input  mem_pkg::axi_s2m_t bus_in
);

    mem_pkg::port_state_e state;

    logic        we_q;
    logic        aw_pend;
    logic        w_pend;
    logic [31:0] addr_q;
    logic [31:0] wdata_q;
    logic [3:0]  wstrb_q;

    logic accept;
    logic ar_hs;
    logic aw_hs;
    logic w_hs;
    logic resp_hs;

    assign accept  = (state == mem_pkg::port_idle) && lsu_req;
    assign ar_hs   = (state == mem_pkg::port_addr) && !we_q && bus_in.arready;
    assign aw_hs   = aw_pend && bus_in.awready;
    assign w_hs    = w_pend && bus_in.wready;
    assign resp_hs = (state == mem_pkg::port_resp) && (we_q ? bus_in.bvalid : bus_in.rvalid);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= mem_pkg::port_idle;
            we_q     <= 1'b0;
            aw_pend  <= 1'b0;
            w_pend   <= 1'b0;
            lsu_done <= 1'b0;
        end else begin
            lsu_done <= resp_hs;
            case (state)
                mem_pkg::port_idle: begin
                    if (accept) begin
                        state   <= mem_pkg::port_addr;
                        we_q    <= lsu_we;
                        aw_pend <= lsu_we;
                        w_pend  <= lsu_we;
                    end
                end
                mem_pkg::port_addr: begin
                    if (we_q) begin
                        // aw and w retire independently
                        if (aw_hs) aw_pend <= 1'b0;
                        if (w_hs) w_pend <= 1'b0;
                        if ((!aw_pend || aw_hs) && (!w_pend || w_hs)) begin
                            state <= mem_pkg::port_resp;
                        end
                    end else if (ar_hs) begin
                        state <= mem_pkg::port_resp;
                    end
                end
                mem_pkg::port_resp: begin
                    if (resp_hs) state <= mem_pkg::port_idle;
                end
                default: begin
                    state <= mem_pkg::port_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= lsu_addr;
            wdata_q <= lsu_wdata;
            wstrb_q <= lsu_wstrb;
        end
        if (resp_hs) begin
            lsu_err <= ((we_q ? bus_in.bresp : bus_in.rresp) != mem_pkg::resp_okay);
            // stores leave the last load data in place
            if (!we_q) lsu_rdata <= bus_in.rdata;
        end
    end

    assign lsu_busy = (state != mem_pkg::port_idle);

    assign bus_out.araddr  = addr_q;
    assign bus_out.arvalid = (state == mem_pkg::port_addr) && !we_q;
    assign bus_out.awaddr  = addr_q;
    assign bus_out.awvalid = aw_pend;
    assign bus_out.wdata   = wdata_q;
    assign bus_out.wstrb   = wstrb_q;
    assign bus_out.wvalid  = w_pend;
    assign bus_out.rready  = 1'b1;
    assign bus_out.bready  = 1'b1;

endmodule

`default_nettype wire

//--- design/mem_subsys_top.sv
`default_nettype none

module mem_subsys_top (
    input  logic        clk,
    input  logic        rst_n,
    // instruction fetch
    input  logic        fetch_req,
    input  logic [31:0] fetch_addr,
    output logic        fetch_busy,
    output logic        fetch_done,
    output logic        fetch_err,
    output logic [31:0] fetch_data,
    // load/store
    input  logic        lsu_req,
    input  logic        lsu_we,
    input  logic [31:0] lsu_addr,
    input  logic [31:0] lsu_wdata,
    input  logic [3:0]  lsu_wstrb,
    output logic        lsu_busy,
    output logic        lsu_done,
    output logic        lsu_err,
    output logic [31:0] lsu_rdata
);

    mem_pkg::axi_m2s_t ifetch_m2s;
    mem_pkg::axi_s2m_t ifetch_s2m;
    mem_pkg::axi_m2s_t lsu_m2s;
    mem_pkg::axi_s2m_t lsu_s2m;
    mem_pkg::axi_m2s_t sram_m2s;
    mem_pkg::axi_s2m_t sram_s2m;

    ifetch_port u_ifetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_busy (fetch_busy),
        .fetch_done (fetch_done),
        .fetch_err  (fetch_err),
        .fetch_data (fetch_data),
        .bus_out    (ifetch_m2s),
        .bus_in     (ifetch_s2m)
    );

    lsu_port u_lsu (
        .clk       (clk),
        .rst_n     (rst_n),
        .lsu_req   (lsu_req),
        .lsu_we    (lsu_we),
        .lsu_addr  (lsu_addr),
        .lsu_wdata (lsu_wdata),
        .lsu_wstrb (lsu_wstrb),
        .lsu_busy  (lsu_busy),
        .lsu_done  (lsu_done),
        .lsu_err   (lsu_err),
        .lsu_rdata (lsu_rdata),
        .bus_out   (lsu_m2s),
        .bus_in    (lsu_s2m)
    );

    axi_lite_arbiter u_arb (
        .clk            (clk),
        .rst_n          (rst_n),
        .ifetch_bus_in  (ifetch_m2s),
        .lsu_bus_in     (lsu_m2s),
        .ifetch_bus_out (ifetch_s2m),
        .lsu_bus_out    (lsu_s2m),
        .sram_bus_out   (sram_m2s),
        .sram_bus_in    (sram_s2m)
    );

    axi_lite_sram u_sram (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_in  (sram_m2s),
        .bus_out (sram_s2m)
    );

endmodule

`default_nettype wire

//--- dv/mem_subsys_tb.sv
`default_nettype none

module mem_subsys_tb;

    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [1:0] {act_lsu, act_fetch, act_both, act_busy} act_e;

    // one row of the stimulus table
    typedef struct packed {
        act_e        act;
        logic        we;
        logic        rand_data;
        logic [31:0] addr;
        logic [31:0] fetch_addr;
        logic [31:0] data;
        logic [3:0]  strb;
    } entry_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        fetch_req;
    logic [31:0] fetch_addr;
    logic        fetch_busy;
    logic        fetch_done;
    logic        fetch_err;
    logic [31:0] fetch_data;
    logic        lsu_req;
    logic        lsu_we;
    logic [31:0] lsu_addr;
    logic [31:0] lsu_wdata;
    logic [3:0]  lsu_wstrb;
    logic        lsu_busy;
    logic        lsu_done;
    logic        lsu_err;
    logic [31:0] lsu_rdata;

    entry_t      tab [$];
    string       names [$];
    logic [31:0] ref_mem [mem_pkg::mem_words];
    integer      seed;
    int          timeout_limit = 0;
    int          cycle_cnt = 0;
    int          lsu_done_cnt = 0;
    int          fetch_done_cnt = 0;
    int          fail_cnt = 0;
    logic        test_failed;
    string       cur_name = "reset";

    mem_subsys_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_busy (fetch_busy),
        .fetch_done (fetch_done),
        .fetch_err  (fetch_err),
        .fetch_data (fetch_data),
        .lsu_req    (lsu_req),
        .lsu_we     (lsu_we),
        .lsu_addr   (lsu_addr),
        .lsu_wdata  (lsu_wdata),
        .lsu_wstrb  (lsu_wstrb),
        .lsu_busy   (lsu_busy),
        .lsu_done   (lsu_done),
        .lsu_err    (lsu_err),
        .lsu_rdata  (lsu_rdata)
    );

    always #4 clk = ~clk;

    // done pulses counted one edge late
    always @(posedge clk) begin
        if (lsu_done) begin
            lsu_done_cnt <= lsu_done_cnt + 1;
        end
        if (fetch_done) begin
            fetch_done_cnt <= fetch_done_cnt + 1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
            $display("timeout after %0d cycles, test %s never saw its done pulse",
                     cycle_cnt, cur_name);
            $display("Test failures found");
            $finish;
        end
    end

    // 1 KiB window
    function automatic logic in_window(input logic [31:0] addr);
        return addr < 32'd1024;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_word(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
        assert (act === exp) else begin
            $display("** Error: %s %s expected %h actual %h", cur_name, what, exp, act);
            test_failed = 1'b1;
        end
    endtask

    task automatic add_entry(input string name, input act_e act, input logic we,
                             input logic rnd, input logic [31:0] addr,
                             input logic [31:0] faddr, input logic [31:0] data,
                             input logic [3:0] strb);
        entry_t e;
        e.act        = act;
        e.we         = we;
        e.rand_data  = rnd;
        e.addr       = addr;
        e.fetch_addr = faddr;
        e.data       = data;
        e.strb       = strb;
        tab.push_back(e);
        names.push_back(name);
    endtask

    task automatic fill_table();
        add_entry("store_word0", act_lsu, 1'b1, 1'b0, 32'h0, 32'h0, 32'h1234_5678, 4'hf);
        add_entry("load_word0", act_lsu, 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 4'hf);
        add_entry("store_rand_w4", act_lsu, 1'b1, 1'b1, 32'h10, 32'h0, 32'h0, 4'hf);
        add_entry("load_rand_w4", act_lsu, 1'b0, 1'b0, 32'h10, 32'h0, 32'h0, 4'hf);
        add_entry("store_full_w8", act_lsu, 1'b1, 1'b0, 32'h20, 32'h0, 32'ha5a5_a5a5, 4'hf);
        add_entry("store_strb_w8", act_lsu, 1'b1, 1'b0, 32'h20, 32'h0, 32'h1122_3344, 4'h5);
        add_entry("load_merged_w8", act_lsu, 1'b0, 1'b0, 32'h20, 32'h0, 32'h0, 4'hf);
        add_entry("store_rand_top", act_lsu, 1'b1, 1'b1, 32'h3fc, 32'h0, 32'h0, 4'hf);
        // fetch sees what lsu wrote
        add_entry("fetch_w0", act_fetch, 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 4'h0);
        add_entry("fetch_top", act_fetch, 1'b0, 1'b0, 32'h0, 32'h3fc, 32'h0, 4'h0);
        add_entry("both_store", act_both, 1'b1, 1'b0, 32'h10, 32'h20, 32'hdead_beef, 4'hf);
        add_entry("both_load", act_both, 1'b0, 1'b0, 32'h10, 32'h3fc, 32'h0, 4'hf);
        add_entry("load_decerr", act_lsu, 1'b0, 1'b0, 32'h400, 32'h0, 32'h0, 4'hf);
        add_entry("store_decerr", act_lsu, 1'b1, 1'b0, 32'h400, 32'h0, 32'hffff_ffff, 4'hf);
        add_entry("fetch_decerr", act_fetch, 1'b0, 1'b0, 32'h0, 32'h1000_0000, 32'h0, 4'h0);
        add_entry("load_w0_after_err", act_lsu, 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 4'hf);
        add_entry("busy_ignored", act_busy, 1'b0, 1'b0, 32'h20, 32'h0, 32'hffff_ffff, 4'hf);
        add_entry("load_after_busy", act_lsu, 1'b0, 1'b0, 32'h20, 32'h0, 32'h0, 4'hf);
    endtask

    task automatic apply_entry(input entry_t e);
        logic [31:0] wdata;
        logic [31:0] exp_data;
        logic        exp_err;
        logic        use_lsu;
        logic        use_fetch;
        logic        fetch_busy_seen;
        int          lsu_start;
        int          fetch_start;

        use_lsu   = (e.act != act_fetch);
        use_fetch = (e.act == act_fetch) || (e.act == act_both);
        fetch_busy_seen = 1'b0;
        if (e.rand_data) begin
            wdata = $random(seed);
        end else begin
            wdata = e.data;
        end
        lsu_start   = lsu_done_cnt;
        fetch_start = fetch_done_cnt;

        @(posedge clk);
        if (use_lsu) begin
            lsu_req   <= 1'b1;
            lsu_we    <= e.we;
            lsu_addr  <= e.addr;
            lsu_wdata <= wdata;
            lsu_wstrb <= e.strb;
        end
        if (use_fetch) begin
            fetch_req  <= 1'b1;
            fetch_addr <= e.fetch_addr;
        end
        @(posedge clk);
        lsu_req   <= 1'b0;
        fetch_req <= 1'b0;

        if (e.act == act_busy) begin
            // a store pulsed while the load is still in flight
            @(posedge clk);
            assert (lsu_busy) else begin
                $display("%s: lsu_busy was low when the second request was pulsed", cur_name);
                test_failed = 1'b1;
            end
            lsu_req   <= 1'b1;
            lsu_we    <= 1'b1;
            lsu_wdata <= wdata;
            lsu_wstrb <= 4'hf;
            @(posedge clk);
            lsu_req <= 1'b0;
        end

        while ((use_lsu && lsu_done_cnt == lsu_start)
               || (use_fetch && fetch_done_cnt == fetch_start)) begin
            @(posedge clk);
            if (fetch_busy) begin
                fetch_busy_seen = 1'b1;
            end
        end

        if (use_lsu) begin
            exp_err = !in_window(e.addr);
            if (e.we) begin
                check_word("lsu_err", {31'b0, exp_err}, {31'b0, lsu_err});
                if (!exp_err) begin
                    ref_mem[e.addr[9:2]] = merge_bytes(ref_mem[e.addr[9:2]], wdata, e.strb);
                end
            end else begin
                exp_data = exp_err ? 32'h0 : ref_mem[e.addr[9:2]];
                check_word("lsu_rdata", exp_data, lsu_rdata);
                check_word("lsu_err", {31'b0, exp_err}, {31'b0, lsu_err});
            end
        end
        if (use_fetch) begin
            exp_err  = !in_window(e.fetch_addr);
            exp_data = exp_err ? 32'h0 : ref_mem[e.fetch_addr[9:2]];
            check_word("fetch_data", exp_data, fetch_data);
            check_word("fetch_err", {31'b0, exp_err}, {31'b0, fetch_err});
            assert (fetch_busy_seen && !fetch_busy) else begin
                $display("%s: fetch_busy did not rise during the fetch or stayed high after it",
                         cur_name);
                test_failed = 1'b1;
            end
        end

        if (e.act == act_busy) begin
            repeat (2) @(posedge clk);
            assert (!lsu_busy && lsu_done_cnt == lsu_start + 1) else begin
                $display("%s: the request pulsed while busy was taken by the lsu port",
                         cur_name);
                test_failed = 1'b1;
            end
        end
    endtask

    initial begin
        seed = 32'ha2ca_2500;
        fill_table();
        // worst case is two full transactions per entry
        timeout_limit = tab.size() * 2 * (8 + 4);

        rst_n      <= 1'b0;
        fetch_req  <= 1'b0;
        fetch_addr <= 32'h0;
        lsu_req    <= 1'b0;
        lsu_we     <= 1'b0;
        lsu_addr   <= 32'h0;
        lsu_wdata  <= 32'h0;
        lsu_wstrb  <= 4'h0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        for (int i = 0; i < tab.size(); i++) begin
            cur_name    = names[i];
            test_failed = 1'b0;
            apply_entry(tab[i]);
            if (test_failed) begin
                fail_cnt++;
                $display("%s: FAIL", cur_name);
            end else begin
                $display("%s: ok", cur_name);
            end
        end

        $display("summary: %0d tests, %0d passed, %0d failed",
                 tab.size(), tab.size() - fail_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
design/mem_pkg.sv
design/axi_lite_sram.sv
design/axi_lite_arbiter.sv
design/ifetch_port.sv
design/lsu_port.sv
design/mem_subsys_top.sv
dv/mem_subsys_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_subsys_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
